// ==== common/conv_pkg.sv ====
package conv_pkg;

  // datapath geometry
  localparam int MEMBERS = 8;
  localparam int KW_MAX  = 4;

  localparam int WORD_W   = 8;
  localparam int PROD_W   = 2 * WORD_W;
  localparam int ACC_W    = 24;
  localparam int KW_W     = 3;

  // signed pixel and weight operands
  typedef logic signed [WORD_W-1:0] word_t;

  // full precision product of one pixel and one weight
  typedef logic signed [PROD_W-1:0] prod_t;

  // accumulator, wide enough for long groups plus the window sum
  typedef logic signed [ACC_W-1:0] acc_t;

  typedef logic [KW_W-1:0] kw_t;  // kernel width, 1 to KW_MAX

  typedef logic [MEMBERS-1:0] member_mask_t;  // one bit per processing element

endpackage

// ==== common/ctrl_pkg.sv ====
package ctrl_pkg;

  localparam int STATE_W = 2;
  localparam int STEP_W  = 2;

  // sequencing phases of one group
  typedef enum logic [STATE_W-1:0] {
    ACCUM,   // taking beats
    DRAIN,   // last products still in the multiplier pipeline
    REDUCE,  // neighbour adds across each kernel window
    OUTPUT   // results presented for one cycle
  } fsm_state_t;

  typedef logic [STEP_W-1:0] step_t;  // reduction step, also a position inside a window

endpackage

// ==== common/pe_ctrl_if.sv ====
`timescale 1ns/1ps

interface pe_ctrl_if;

  logic                   mul_en;     // beat accepted this cycle
  logic                   first;      // beat opens a new group
  logic                   reduce_en;  // one reduction step this cycle
  conv_pkg::member_mask_t add_mask;   // members that take their left neighbour

  modport ctrl (
    output mul_en,
    output first,
    output reduce_en,
    output add_mask
  );

  modport pe (
    input mul_en,
    input first,
    input reduce_en,
    input add_mask
  );

endinterface

// ==== hdl/conv_fsm.sv ====
`timescale 1ns/1ps

module conv_fsm (
  input  logic    clk,
  input  logic    arst_n,
  input  logic    s_valid,
  input  logic    s_last,
  output logic    s_ready,
  input  logic    reduce_done,
  output logic    start_reduce,
  output logic    m_valid,
  pe_ctrl_if.ctrl ctrl
);

  ctrl_pkg::fsm_state_t state_q;
  ctrl_pkg::fsm_state_t state_d;
  logic                 first_q;
  logic                 drain_q;
  logic                 accept;

  assign s_ready      = (state_q == ctrl_pkg::ACCUM);
  assign accept       = s_valid && s_ready;
  assign start_reduce = (state_q == ctrl_pkg::DRAIN) && drain_q;  // second drain cycle
  assign m_valid      = (state_q == ctrl_pkg::OUTPUT);

  assign ctrl.mul_en    = accept;
  assign ctrl.first     = first_q;
  assign ctrl.reduce_en = (state_q == ctrl_pkg::REDUCE);

  // DRAIN spans two cycles so the last product lands before any neighbour add
  always_comb begin
    state_d = state_q;
    case (state_q)
      ctrl_pkg::ACCUM: begin
        if (accept && s_last) state_d = ctrl_pkg::DRAIN;
      end
      ctrl_pkg::DRAIN: begin
        if (drain_q) state_d = reduce_done ? ctrl_pkg::OUTPUT : ctrl_pkg::REDUCE;
      end
      ctrl_pkg::REDUCE: begin
        if (reduce_done) state_d = ctrl_pkg::OUTPUT;
      end
      ctrl_pkg::OUTPUT: begin
        state_d = ctrl_pkg::ACCUM;
      end
      default: begin
        state_d = ctrl_pkg::ACCUM;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= ctrl_pkg::ACCUM;
      drain_q <= 1'b0;
      first_q <= 1'b1;
    end else begin
      state_q <= state_d;
      drain_q <= (state_q == ctrl_pkg::DRAIN) && !drain_q;
      if (state_q == ctrl_pkg::OUTPUT) begin
        first_q <= 1'b1;  // next accepted beat reloads the accumulators
      end else if (accept) begin
        first_q <= 1'b0;
      end
    end
  end

  a_m_valid_pulse : assert property (@(posedge clk) disable iff (!arst_n)
    m_valid |=> (!m_valid && s_ready));

  // the counter ends a window within KW_MAX - 1 reduction steps
  a_reduce_bound : assert property (@(posedge clk) disable iff (!arst_n)
    (ctrl.reduce_en && $past(ctrl.reduce_en) && $past(ctrl.reduce_en, 2)) |-> reduce_done);

endmodule

// ==== hdl/reduce_counter.sv ====
`timescale 1ns/1ps

module reduce_counter (
  input  logic                   clk,
  input  logic                   arst_n,
  input  conv_pkg::kw_t          s_kw,
  input  logic                   latch_kw,
  input  logic                   start_reduce,
  output logic                   reduce_done,
  output conv_pkg::member_mask_t add_mask,
  output conv_pkg::member_mask_t keep_mask
);

  conv_pkg::kw_t   kw_q;
  ctrl_pkg::step_t step_q;
  ctrl_pkg::step_t last_pos;
  ctrl_pkg::step_t pos [conv_pkg::MEMBERS];

  assign last_pos = ctrl_pkg::step_t'(kw_q - conv_pkg::kw_t'(1));

  // step 0 means idle, so kw of 1 reports done straight away
  assign reduce_done = (step_q == last_pos);

  for (genvar m = 0; m < conv_pkg::MEMBERS; m++) begin : g_member
    assign pos[m]       = ctrl_pkg::step_t'(m % kw_q);
    assign add_mask[m]  = (step_q != '0) && (pos[m] == step_q);
    // the tail member keeps a partial sum
    assign keep_mask[m] = (pos[m] == last_pos) || (m == conv_pkg::MEMBERS - 1);
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      kw_q   <= conv_pkg::kw_t'(1);
      step_q <= '0;
    end else begin
      if (latch_kw) begin
        kw_q <= s_kw;
      end
      if (start_reduce && (last_pos != '0)) begin
        step_q <= ctrl_pkg::step_t'(1);
      end else if (step_q != '0) begin
        step_q <= reduce_done ? '0 : step_q + ctrl_pkg::step_t'(1);
      end
    end
  end

  a_kw_range : assert property (@(posedge clk) disable iff (!arst_n)
    latch_kw |=> (kw_q >= 1 && kw_q <= conv_pkg::KW_MAX));

endmodule

// ==== conv_array/processing_element.sv ====
`timescale 1ns/1ps

module processing_element (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            mul_en,
  input  logic            first,
  input  logic            reduce_en,
  input  logic            add_sel,
  input  conv_pkg::word_t pixel,
  input  conv_pkg::word_t weight,
  input  conv_pkg::acc_t  left_acc,
  output conv_pkg::acc_t  acc
);

  conv_pkg::word_t pixel_q;
  conv_pkg::word_t weight_q;
  conv_pkg::prod_t prod_q;
  conv_pkg::acc_t  prod_ext;
  logic            in_valid_q;
  logic            in_first_q;
  logic            prod_valid_q;
  logic            prod_first_q;

  assign prod_ext = conv_pkg::acc_t'(prod_q);  // sign extension

  always_ff @(posedge clk) begin
    if (mul_en) begin
      pixel_q  <= pixel;
      weight_q <= weight;
    end
    if (in_valid_q) begin
      prod_q <= pixel_q * weight_q;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      in_valid_q   <= 1'b0;
      in_first_q   <= 1'b0;
      prod_valid_q <= 1'b0;
      prod_first_q <= 1'b0;
      acc          <= '0;
    end else begin
      in_valid_q   <= mul_en;
      in_first_q   <= mul_en && first;
      prod_valid_q <= in_valid_q;
      prod_first_q <= in_first_q;
      if (prod_valid_q) begin
        acc <= prod_first_q ? prod_ext : acc + prod_ext;  // a first beat drops the old sum
      end else if (reduce_en && add_sel) begin
        acc <= acc + left_acc;
      end
    end
  end

  a_no_overlap : assert property (@(posedge clk) disable iff (!arst_n)
    !(prod_valid_q && reduce_en));

endmodule

// ==== conv_array/pe_array.sv ====
`timescale 1ns/1ps

module pe_array (
  input  logic            clk,
  input  logic            arst_n,
  pe_ctrl_if.pe           ctrl,
  input  conv_pkg::word_t s_pixel,
  input  conv_pkg::word_t s_weights [conv_pkg::MEMBERS],
  output conv_pkg::acc_t  m_data    [conv_pkg::MEMBERS]
);

  conv_pkg::acc_t left_acc [conv_pkg::MEMBERS];

  // the chain runs from member 0 upwards, member 0 has nothing on its left
  assign left_acc[0] = '0;

  for (genvar m = 1; m < conv_pkg::MEMBERS; m++) begin : g_chain
    assign left_acc[m] = m_data[m-1];
  end

  for (genvar m = 0; m < conv_pkg::MEMBERS; m++) begin : g_pe
    processing_element processing_element_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .mul_en    (ctrl.mul_en),
      .first     (ctrl.first),
      .reduce_en (ctrl.reduce_en),
      .add_sel   (ctrl.add_mask[m]),
      .pixel     (s_pixel),  // one pixel shared across the row
      .weight    (s_weights[m]),
      .left_acc  (left_acc[m]),
      .acc       (m_data[m])
    );
  end

endmodule

// ==== hdl/conv_engine.sv ====
`timescale 1ns/1ps

module conv_engine (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   s_valid,
  output logic                   s_ready,
  input  logic                   s_last,
  input  conv_pkg::kw_t          s_kw,
  input  conv_pkg::word_t        s_pixel,
  input  conv_pkg::word_t        s_weights [conv_pkg::MEMBERS],
  output logic                   m_valid,
  output conv_pkg::member_mask_t m_keep,
  output conv_pkg::acc_t         m_data    [conv_pkg::MEMBERS]
);

  logic start_reduce;
  logic reduce_done;

  pe_ctrl_if pe_ctrl ();

  conv_fsm conv_fsm_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .s_valid      (s_valid),
    .s_last       (s_last),
    .s_ready      (s_ready),
    .reduce_done  (reduce_done),
    .start_reduce (start_reduce),
    .m_valid      (m_valid),
    .ctrl         (pe_ctrl)
  );

  reduce_counter reduce_counter_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .s_kw         (s_kw),
    .latch_kw     (pe_ctrl.mul_en && pe_ctrl.first),  // kw is taken from the opening beat
    .start_reduce (start_reduce),
    .reduce_done  (reduce_done),
    .add_mask     (pe_ctrl.add_mask),
    .keep_mask    (m_keep)
  );

  pe_array pe_array_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .ctrl      (pe_ctrl),
    .s_pixel   (s_pixel),
    .s_weights (s_weights),
    .m_data    (m_data)
  );

endmodule

// ==== bench/conv_engine_tb.sv ====
`timescale 1ns/1ps

module conv_engine_tb;

  localparam int N_GROUPS     = 40;
  localparam int MAX_LEN      = 6;
  localparam int MAX_GAP      = 3;
  localparam int GROUP_CYCLES = MAX_LEN + conv_pkg::KW_MAX + 4 + MAX_LEN * MAX_GAP;
  localparam int LIMIT_CYCLES = 10 + N_GROUPS * GROUP_CYCLES + 50;

  logic                   clk;
  logic                   arst_n;
  logic                   s_valid;
  logic                   s_ready;
  logic                   s_last;
  conv_pkg::kw_t          s_kw;
  conv_pkg::word_t        s_pixel;
  conv_pkg::word_t        s_weights [conv_pkg::MEMBERS];
  logic                   m_valid;
  conv_pkg::member_mask_t m_keep;
  conv_pkg::acc_t         m_data    [conv_pkg::MEMBERS];

  logic [15:0]            lfsr_q;
  int                     model_acc [conv_pkg::MEMBERS];
  int                     exp_acc   [conv_pkg::MEMBERS];
  conv_pkg::member_mask_t exp_keep;
  int                     model_kw;
  logic                   model_first;
  int                     errors;
  int                     checks;
  int                     edge_cnt;
  int                     exp_edge;
  logic                   pending;
  logic                   busy;
  logic                   clear_busy;
  logic                   prev_m_valid;
  logic                   ready_seen;
  int                     groups_sent;
  int                     groups_checked;
  int                     beat_idx;
  int                     grp_len;
  int                     grp_kw;
  int                     gap_left;

  conv_engine conv_engine_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .s_valid   (s_valid),
    .s_ready   (s_ready),
    .s_last    (s_last),
    .s_kw      (s_kw),
    .s_pixel   (s_pixel),
    .s_weights (s_weights),
    .m_valid   (m_valid),
    .m_keep    (m_keep),
    .m_data    (m_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    logic fb;
    fb = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], fb};
  endfunction

  function automatic int take_bits(input int n);
    int value;
    int i;
    value = 0;
    for (i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      value  = (value << 1) | int'(lfsr_q[0]);
    end
    return value;
  endfunction

  function automatic conv_pkg::word_t rand_word();
    int zero_pick;
    int raw;
    zero_pick = take_bits(3);
    raw       = take_bits(conv_pkg::WORD_W);
    return (zero_pick == 0) ? conv_pkg::word_t'(0) : conv_pkg::word_t'(raw);  // one in eight is zero
  endfunction

  task automatic check_value(input string name, input logic [conv_pkg::ACC_W-1:0] got,
                             input logic [conv_pkg::ACC_W-1:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  // window sums built one step at a time, each member at position t takes its left neighbour
  task automatic build_expected();
    int t;
    int m;
    for (m = 0; m < conv_pkg::MEMBERS; m++) begin
      exp_acc[m] = model_acc[m];
    end
    for (t = 1; t < model_kw; t++) begin
      for (m = 1; m < conv_pkg::MEMBERS; m++) begin
        if (m % model_kw == t) begin
          exp_acc[m] = exp_acc[m] + exp_acc[m-1];
        end
      end
    end
    for (m = 0; m < conv_pkg::MEMBERS; m++) begin
      exp_keep[m] = (m % model_kw == model_kw - 1) || (m == conv_pkg::MEMBERS - 1);
    end
  endtask

  task automatic accept_beat();
    int m;
    int prod;
    if (model_first) begin
      model_kw = int'(s_kw);
    end
    for (m = 0; m < conv_pkg::MEMBERS; m++) begin
      prod         = int'(s_pixel) * int'(s_weights[m]);
      model_acc[m] = model_first ? prod : model_acc[m] + prod;
    end
    model_first = 1'b0;
    if (s_last) begin
      build_expected();
      exp_edge    = edge_cnt + model_kw + 1;  // two pipeline edges, then kw - 1 steps
      pending     = 1'b1;
      busy        = 1'b1;
      model_first = 1'b1;
    end
  endtask

  task automatic check_outputs();
    int m;
    check_value("s_ready", conv_pkg::ACC_W'(s_ready), conv_pkg::ACC_W'(!busy));
    if (m_valid) begin
      checks++;
      assert (pending && !prev_m_valid && edge_cnt == exp_edge) else begin
        errors++;
        $display("m_valid came at edge %0d, but the next result was due at edge %0d",
                 edge_cnt, exp_edge);
      end
      for (m = 0; m < conv_pkg::MEMBERS; m++) begin
        check_value($sformatf("m_data[%0d]", m), m_data[m], conv_pkg::acc_t'(exp_acc[m]));
      end
      check_value("m_keep", conv_pkg::ACC_W'(m_keep), conv_pkg::ACC_W'(exp_keep));
      pending    = 1'b0;
      clear_busy = 1'b1;
      groups_checked++;
    end else if (pending) begin
      assert (edge_cnt < exp_edge) else begin
        errors++;
        $display("m_valid did not come at edge %0d", exp_edge);
        pending    = 1'b0;
        clear_busy = 1'b1;
        groups_checked++;
      end
    end
    prev_m_valid = m_valid;
  endtask

  task automatic drive_inputs();
    int m;
    if (!s_valid) begin  // a refused beat stays on the bus unchanged
      if (gap_left > 0) begin
        gap_left--;
      end else if (groups_sent < N_GROUPS) begin
        if (beat_idx == 0) begin
          grp_len = take_bits(3) % MAX_LEN + 1;
          grp_kw  = take_bits(2) + 1;
        end
        s_valid = 1'b1;
        s_kw    = conv_pkg::kw_t'(grp_kw);
        s_pixel = rand_word();
        for (m = 0; m < conv_pkg::MEMBERS; m++) begin
          s_weights[m] = rand_word();
        end
        s_last = (beat_idx == grp_len - 1);
        if (s_last) begin
          beat_idx = 0;
          groups_sent++;
        end else begin
          beat_idx++;
        end
        gap_left = (take_bits(1) == 1) ? take_bits(2) : 0;  // half the beats come back to back
      end
    end
  endtask

  initial begin
    lfsr_q         = 16'd76;
    errors         = 0;
    checks         = 0;
    edge_cnt       = 0;
    exp_edge       = 0;
    pending        = 1'b0;
    busy           = 1'b0;
    clear_busy     = 1'b0;
    prev_m_valid   = 1'b0;
    ready_seen     = 1'b0;
    model_first    = 1'b1;
    model_kw       = 1;
    exp_keep       = '0;
    groups_sent    = 0;
    groups_checked = 0;
    beat_idx       = 0;
    grp_len        = 1;
    grp_kw         = 1;
    gap_left       = 0;
    for (int m = 0; m < conv_pkg::MEMBERS; m++) begin
      s_weights[m] = '0;
      model_acc[m] = 0;
      exp_acc[m]   = 0;
    end
    arst_n  = 1'b0;
    s_valid = 1'b0;
    s_last  = 1'b0;
    s_kw    = conv_pkg::kw_t'(1);
    s_pixel = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    while (groups_checked < N_GROUPS) begin
      @(negedge clk);
      edge_cnt++;
      if (clear_busy) begin
        busy       = 1'b0;
        clear_busy = 1'b0;
      end
      if (s_valid && ready_seen) begin  // taken at the edge just passed
        accept_beat();
        s_valid = 1'b0;
      end
      check_outputs();
      ready_seen = s_ready;
      drive_inputs();
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    repeat (LIMIT_CYCLES) @(posedge clk);
    $display("timeout: only %0d of %0d groups finished within %0d cycles",
             groups_checked, N_GROUPS, LIMIT_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== verilog.f ====
common/conv_pkg.sv
common/ctrl_pkg.sv
common/pe_ctrl_if.sv
hdl/conv_fsm.sv
hdl/reduce_counter.sv
conv_array/processing_element.sv
conv_array/pe_array.sv
hdl/conv_engine.sv
bench/conv_engine_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench, the log decides pass or fail
verilator --binary --timing --assert -Wno-fatal --top-module conv_engine_tb \
  -f verilog.f -o conv_engine_sim \
  && ./obj_dir/conv_engine_sim > sim.log 2>&1 \
  && cat sim.log \
  && ! grep -q "FAIL: see errors above" sim.log \
  && echo "simulation passed" \
  || { cat sim.log 2>/dev/null; echo "simulation failed"; exit 1; }
